// ==== compile.f ====
hdl/vic_pkg.sv
hdl/vic_bus_regs.sv
hdl/msg_fifo.sv
hdl/serial_tx.sv
hdl/vic_mcu_link.sv
tb/link_checker.sv
tb/tb_vic_mcu_link.sv

// ==== tb/tb_vic_mcu_link.sv ====
`timescale 1ns/1ns

module tb_vic_mcu_link;
  import vic_pkg::*;

  localparam int fifo_depth   = 4;
  localparam int clks_per_bit = 8;
  localparam int cclk_stable  = 16;
  localparam int frame_cycles = 10 * clks_per_bit;  // start, 8 data, stop
  localparam int n_scratch    = 8;
  localparam int n_msg        = 6;
  localparam int n_prio       = 3;
  localparam int n_frames     = 1 + n_msg + 2 * n_prio + fifo_depth;
  // every frame with room to wait behind another, plus bus traffic and reset
  localparam int timeout_cycles = 3 * (n_frames + n_msg) * frame_cycles
                                + 20 * n_scratch + 1000;

  logic       sys_clock;
  logic       reset;
  logic [1:0] chip;
  logic       is_15khz;
  logic       is_hide_raster_lines;
  logic       ce;
  logic       rw;
  logic [5:0] adi;
  logic [7:0] dbi;
  logic       cclk;
  logic [7:0] dbo;
  logic       vic_write_db;
  logic       tx;
  logic       link_ready;

  int          cycles = 0;
  int          other_errors = 0;
  int          tx_errors;
  int          dbo_errors;
  int          frame_errors;
  logic [31:0] lcg_state = 32'd31566;
  logic [7:0]  scratch_m;        // model of reg_scratch
  logic [7:0]  drops_m = 8'h00;  // model of reg_drops
  logic [7:0]  last_msg_m;       // last byte reg_mcu_msg accepted
  logic [7:0]  r;
  int          kept;

  vic_mcu_link #(
    .FIFO_DEPTH  (fifo_depth),
    .CLKS_PER_BIT(clks_per_bit),
    .CCLK_STABLE (cclk_stable)
  ) UUT (
    .sys_clock, .reset, .chip, .is_15khz, .is_hide_raster_lines,
    .ce, .rw, .adi, .dbi, .cclk, .dbo, .vic_write_db, .tx, .link_ready
  );

  link_checker #(
    .CLKS_PER_BIT(clks_per_bit)
  ) link_chk (
    .sys_clock, .reset, .ce, .rw, .tx, .dbo, .vic_write_db,
    .tx_errors, .dbo_errors, .frame_errors
  );

  initial begin
    sys_clock = 1'b0;
    forever #10 sys_clock = ~sys_clock;
  end

  always @(posedge sys_clock) cycles <= cycles + 1;

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];  // high bits spread best
  endfunction

  // tag C on top, then chip, 15 khz, hide raster lines
  function automatic logic [7:0] cfg_report(input logic [1:0] c, input logic k, input logic h);
    return {4'hc, c, k, h};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge sys_clock);
      #2;  // inputs change just after the edge
    end
  endtask

  task automatic wait_drain();
    while (link_chk.bytes_left() != 0)
      wait_cycles(1);
  endtask

  // one request per call, each one cycle wide
  task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
    ce  = 1'b0;
    rw  = 1'b0;
    adi = addr;
    dbi = data;
    wait_cycles(1);
    ce = 1'b1;
    rw = 1'b1;
  endtask

  task automatic bus_read(input logic [5:0] addr, input logic [7:0] exp);
    link_chk.expect_read(exp);
    ce  = 1'b0;
    rw  = 1'b1;
    adi = addr;
    wait_cycles(1);
    ce = 1'b1;
  endtask

  task automatic check_idle();
    if (tx !== 1'b1) begin
      $display("Fail tx exp=%h got=%h", 1'b1, tx);
      other_errors++;
    end
    if (link_ready !== 1'b0) begin
      $display("Fail link_ready exp=%h got=%h", 1'b0, link_ready);
      other_errors++;
    end
  endtask

  task automatic end_run(input bit timed_out);
    int total;
    total = other_errors + tx_errors + dbo_errors + frame_errors;
    $display("errors: tx=%0d dbo=%0d framing=%0d other=%0d",
             tx_errors, dbo_errors, frame_errors, other_errors);
    if (total == 0 && !timed_out)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  endtask

  initial begin
    reset = 1'b1;
    ce    = 1'b1;
    rw    = 1'b1;
    adi   = 6'd0;
    dbi   = 8'h00;
    cclk  = 1'b0;  // mcu not ready yet
    {chip, is_15khz, is_hide_raster_lines} = 4'(rand_byte());
    repeat (16) @(posedge sys_clock);
    #2 reset = 1'b0;

    // reset state, config byte waits in the fifo while cclk is low
    for (int i = 0; i < 8; i++) begin
      check_idle();
      wait_cycles(1);
    end
    link_chk.expect_byte(cfg_report(chip, is_15khz, is_hide_raster_lines));
    cclk = 1'b1;
    for (int i = 0; i < cclk_stable; i++) begin
      wait_cycles(1);
      check_idle();  // filter still counting
    end
    wait_drain();

    // scratch register
    for (int i = 0; i < n_scratch; i++) begin
      scratch_m = rand_byte();
      bus_write(reg_scratch, scratch_m);
      wait_cycles(rand_byte() & 8'h3);
      bus_read(reg_scratch, scratch_m);
    end

    // messages spaced one frame apart, fifo never fills
    for (int i = 0; i < n_msg; i++) begin
      last_msg_m = rand_byte();
      link_chk.expect_byte(last_msg_m);
      bus_write(reg_mcu_msg, last_msg_m);
      wait_cycles(frame_cycles + (rand_byte() & 8'h7));
    end
    wait_drain();
    bus_read(reg_mcu_msg, last_msg_m);

    // pin change in the same cycle as a message write
    for (int i = 0; i < n_prio; i++) begin
      r = rand_byte();
      if (r[0])
        chip = chip ^ ((r[2:1] == 2'b00) ? 2'b01 : r[2:1]);  // always a real change
      else
        is_15khz = !is_15khz;
      last_msg_m = rand_byte();
      link_chk.expect_byte(cfg_report(chip, is_15khz, is_hide_raster_lines));
      link_chk.expect_byte(last_msg_m);  // config goes out first
      bus_write(reg_mcu_msg, last_msg_m);
      wait_drain();
    end

    // overflow burst with the link held off
    wait_cycles(frame_cycles);
    cclk = 1'b0;
    while (link_ready)
      wait_cycles(1);
    kept = 0;
    for (int i = 0; i < fifo_depth + 3; i++) begin
      r = rand_byte();
      if (kept < fifo_depth) begin
        link_chk.expect_byte(r);
        last_msg_m = r;
        kept++;
      end else if (drops_m != 8'hff) begin
        drops_m++;  // saturating
      end
      bus_write(reg_mcu_msg, r);
    end
    wait_cycles(4);  // slot settles into the fifo
    bus_read(reg_drops, drops_m);
    bus_read(reg_status, {4'(fifo_depth), chip, is_15khz, is_hide_raster_lines});
    bus_read(reg_mcu_msg, last_msg_m);
    check_idle();
    cclk = 1'b1;
    wait_drain();
    wait_cycles(2 * frame_cycles);  // a stray extra frame would finish in here
    if (link_chk.reads_left() != 0) begin
      $display("%0d read answers never came back", link_chk.reads_left());
      other_errors++;
    end
    end_run(1'b0);
  end

  initial begin
    wait (cycles >= timeout_cycles);
    $display("timeout, run stopped after %0d cycles", cycles);
    other_errors++;
    end_run(1'b1);
  end

endmodule : tb_vic_mcu_link

// ==== tb/link_checker.sv ====
`timescale 1ns/1ns

module link_checker #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       sys_clock,
  input  logic       reset,
  input  logic       ce,
  input  logic       rw,
  input  logic       tx,
  input  logic [7:0] dbo,
  input  logic       vic_write_db,
  output int         tx_errors,
  output int         dbo_errors,
  output int         frame_errors
);

  logic [7:0] exp_bytes [$];  // bytes the model expects on tx, oldest first
  logic [7:0] exp_reads [$];  // answers owed to reads already issued
  logic [7:0] exp_rd;
  logic [7:0] exp_tx;
  logic [7:0] rx_byte;        // frame being rebuilt from tx
  logic       rd_seen = 1'b0; // read request sampled at the previous edge

  initial begin
    tx_errors    = 0;
    dbo_errors   = 0;
    frame_errors = 0;
  end

  // called by the model in the testbench top
  task automatic expect_byte(input logic [7:0] b);
    exp_bytes.push_back(b);
  endtask

  task automatic expect_read(input logic [7:0] d);
    exp_reads.push_back(d);
  endtask

  function automatic int bytes_left();
    return exp_bytes.size();
  endfunction

  function automatic int reads_left();
    return exp_reads.size();
  endfunction

  // read port, answer shows up with vic_write_db, idle bus is zero
  always @(posedge sys_clock) begin
    if (!reset) begin
      if (vic_write_db !== rd_seen) begin
        $display("Fail vic_write_db exp=%h got=%h", rd_seen, vic_write_db);  // one cycle late
        dbo_errors++;
      end
      if (vic_write_db === 1'b1) begin
        if (exp_reads.size() == 0) begin
          $display("read answer on dbo with no read outstanding");
          dbo_errors++;
        end else begin
          exp_rd = exp_reads.pop_front();
          if (dbo !== exp_rd) begin
            $display("Fail dbo exp=%h got=%h", exp_rd, dbo);
            dbo_errors++;
          end
        end
      end else if (dbo !== 8'h00) begin
        $display("Fail dbo exp=%h got=%h", 8'h00, dbo);  // should idle at zero
        dbo_errors++;
      end
    end
    rd_seen = (ce === 1'b0) && (rw === 1'b1);
  end

  // tx side, first low sample marks the start bit
  always begin : frame_watch
    @(posedge sys_clock);
    if (!reset && tx === 1'b0) begin
      repeat (CLKS_PER_BIT / 2 - 1) @(posedge sys_clock);  // to the middle of the start bit
      if (tx !== 1'b0) begin
        $display("start bit on tx did not last to the middle of the bit");
        frame_errors++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(posedge sys_clock);
        rx_byte[i] = tx;  // lsb first
      end
      repeat (CLKS_PER_BIT) @(posedge sys_clock);
      if (tx !== 1'b1) begin
        $display("framing error, stop bit on tx was low");
        frame_errors++;
      end
      if (exp_bytes.size() == 0) begin
        $display("tx sent a frame while no byte was expected");
        tx_errors++;
      end else begin
        exp_tx = exp_bytes.pop_front();
        if (rx_byte !== exp_tx) begin
          $display("Fail tx_byte exp=%h got=%h", exp_tx, rx_byte);
          tx_errors++;
        end
      end
    end
  end

endmodule : link_checker

// ==== hdl/vic_mcu_link.sv ====
`timescale 1ns/1ns

module vic_mcu_link #(
  parameter int FIFO_DEPTH   = 4,   // power of two
  parameter int CLKS_PER_BIT = 8,
  parameter int CCLK_STABLE  = 16
) (
  input  logic       sys_clock,
  input  logic       reset,
  input  logic [1:0] chip,
  input  logic       is_15khz,
  input  logic       is_hide_raster_lines,
  input  logic       ce,      // low = selected
  input  logic       rw,      // low = write
  input  logic [5:0] adi,
  input  logic [7:0] dbi,
  input  logic       cclk,    // mcu ready line
  output logic [7:0] dbo,
  output logic       vic_write_db,
  output logic       tx,      // 8n1 to the mcu
  output logic       link_ready
);
  import vic_pkg::*;

  bus_req_t                    bus_req;
  msg_t                        enq;         // reporter to fifo
  msg_t                        head;        // fifo to transmitter
  logic                        enq_ready;
  logic                        head_ready;
  logic [$clog2(FIFO_DEPTH):0] fifo_count;

  assign bus_req = '{ce: ce, rw: rw, addr: adi, data: dbi};

  vic_bus_regs #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_bus_regs (
    .sys_clock           (sys_clock),
    .reset               (reset),
    .bus_req             (bus_req),
    .chip                (chip),
    .is_15khz            (is_15khz),
    .is_hide_raster_lines(is_hide_raster_lines),
    .fifo_count          (fifo_count),
    .enq                 (enq),
    .enq_ready           (enq_ready),
    .dbo                 (dbo),
    .vic_write_db        (vic_write_db)
  );

  msg_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_msg_fifo (
    .sys_clock (sys_clock),
    .reset     (reset),
    .enq       (enq),
    .enq_ready (enq_ready),
    .head      (head),
    .head_ready(head_ready),
    .count     (fifo_count)
  );

  serial_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .CCLK_STABLE (CCLK_STABLE)
  ) u_serial_tx (
    .sys_clock (sys_clock),
    .reset     (reset),
    .cclk      (cclk),
    .head      (head),
    .head_ready(head_ready),
    .tx        (tx),
    .link_ready(link_ready)
  );

endmodule : vic_mcu_link

// ==== hdl/serial_tx.sv ====
`timescale 1ns/1ns

module serial_tx #(
  parameter int CLKS_PER_BIT = 8,
  parameter int CCLK_STABLE  = 16
) (
  input  logic          sys_clock,
  input  logic          reset,
  input  logic          cclk,
  input  vic_pkg::msg_t head,
  output logic          head_ready,
  output logic          tx,
  output logic          link_ready
);
  import vic_pkg::*;

  localparam int bit_w    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int stable_w = $clog2(CCLK_STABLE + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_t;

  tx_state_t         state;
  logic              cclk_s1;     // cclk comes from the mcu, asynchronous
  logic              cclk_s2;
  logic [stable_w-1:0] stable_cnt;  // consecutive high samples
  logic [bit_w-1:0]  clk_cnt;     // position inside one bit period
  logic [2:0]        bit_idx;     // data bit being sent
  logic [7:0]        shift_q;     // lsb goes out first
  logic              bit_end;

  // readiness filter
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      cclk_s1    <= 1'b0;
      cclk_s2    <= 1'b0;
      stable_cnt <= '0;
      link_ready <= 1'b0;
    end else begin
      cclk_s1 <= cclk;
      cclk_s2 <= cclk_s1;
      if (!cclk_s2) begin
        stable_cnt <= '0;
        link_ready <= 1'b0;  // drops right after a low sample
      end else if (stable_cnt != stable_w'(CCLK_STABLE)) begin
        stable_cnt <= stable_cnt + 1'b1;
      end else begin
        link_ready <= 1'b1;
      end
    end
  end

  // take a byte only from idle, so never before the last stop bit ends
  assign head_ready = state == st_idle && link_ready && head.valid;
  assign bit_end    = clk_cnt == bit_w'(CLKS_PER_BIT - 1);

  // line idles high, start is 0, stop is 1
  assign tx = (state == st_start) ? 1'b0 :
              (state == st_data)  ? shift_q[0] : 1'b1;

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      state   <= st_idle;
      clk_cnt <= '0;
      bit_idx <= 3'd0;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          if (head_ready)
            state <= st_start;
        end
        st_start: if (bit_end) begin
          state   <= st_data;
          bit_idx <= 3'd0;
        end
        st_data: if (bit_end) begin
          bit_idx <= bit_idx + 3'd1;
          if (bit_idx == 3'd7)
            state <= st_stop;
        end
        st_stop: if (bit_end)
          state <= st_idle;  // frame always completes, cclk or not
        default: state <= st_idle;
      endcase
    end
  end

  // frame payload
  always_ff @(posedge sys_clock) begin
    if (head_ready)
      shift_q <= head.data;
    else if (state == st_data && bit_end)
      shift_q <= {1'b1, shift_q[7:1]};
  end

endmodule : serial_tx

// ==== hdl/msg_fifo.sv ====
`timescale 1ns/1ns

module msg_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        sys_clock,
  input  logic                        reset,
  input  vic_pkg::msg_t               enq,
  output logic                        enq_ready,
  output vic_pkg::msg_t               head,
  input  logic                        head_ready,
  output logic [$clog2(FIFO_DEPTH):0] count
);
  import vic_pkg::*;

  localparam int ptr_w = $clog2(FIFO_DEPTH);  // depth is a power of two

  logic [7:0]       mem [FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;  // wraps by itself
  logic [ptr_w-1:0] rd_ptr;
  logic             full;
  logic             push;
  logic             pop;

  assign full = count == (ptr_w + 1)'(FIFO_DEPTH);

  // a full fifo still takes a byte when the head leaves in the same cycle
  assign enq_ready = !full || head_ready;

  assign head.valid = count != '0;
  assign head.data  = mem[rd_ptr];  // oldest byte

  assign push = enq.valid && enq_ready;
  assign pop  = head.valid && head_ready;

  always_ff @(posedge sys_clock) begin
    if (push)
      mem[wr_ptr] <= enq.data;
  end

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop together
      endcase
    end
  end

endmodule : msg_fifo

// ==== hdl/vic_bus_regs.sv ====
`timescale 1ns/1ns

module vic_bus_regs #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        sys_clock,
  input  logic                        reset,
  input  vic_pkg::bus_req_t           bus_req,
  input  logic [1:0]                  chip,
  input  logic                        is_15khz,
  input  logic                        is_hide_raster_lines,
  input  logic [$clog2(FIFO_DEPTH):0] fifo_count,
  output vic_pkg::msg_t               enq,
  input  logic                        enq_ready,
  output logic [7:0]                  dbo,
  output logic                        vic_write_db
);
  import vic_pkg::*;

  localparam int count_w = $clog2(FIFO_DEPTH) + 1;

  logic [7:0]       scratch_q;
  logic [7:0]       drops_q;
  logic [7:0]       mcu_msg_q;   // last message byte accepted
  logic             wr_req;
  logic             rd_req;
  logic [7:0]       rd_data;
  logic [3:0]       cfg_pins;    // {chip, is_15khz, is_hide_raster_lines}
  logic [3:0]       cfg_q;       // registered copy of the pins
  logic             started_q;   // first cycle out of reset still to come
  logic             cfg_pend;    // config report waiting for the fifo
  logic             msg_valid;   // one entry message slot
  logic [7:0]       msg_data;
  logic             cfg_move;
  logic             msg_move;
  logic             msg_wr;
  logic             msg_drop;
  logic [count_w:0] occupancy;   // bytes in or committed to the fifo

  assign wr_req   = !bus_req.ce && !bus_req.rw;
  assign rd_req   = !bus_req.ce && bus_req.rw;
  assign cfg_pins = {chip, is_15khz, is_hide_raster_lines};

  // read mux, sampled into dbo one cycle after the request
  always_comb begin
    case (bus_req.addr)
      reg_scratch: rd_data = scratch_q;
      reg_status:  rd_data = {4'(fifo_count), cfg_q};  // count replaces the tag
      reg_drops:   rd_data = drops_q;
      reg_mcu_msg: rd_data = mcu_msg_q;
      default:     rd_data = 8'h00;
    endcase
  end

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      dbo          <= 8'h00;
      vic_write_db <= 1'b0;
      scratch_q    <= 8'h00;
    end else begin
      vic_write_db <= rd_req;                    // high for exactly the answer cycle
      dbo          <= rd_req ? rd_data : 8'h00;  // bus idles at zero
      if (wr_req && bus_req.addr == reg_scratch)
        scratch_q <= bus_req.data;
    end
  end

  // config reporter
  // report once out of reset and again on every pin change
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      cfg_q     <= 4'h0;
      started_q <= 1'b0;
      cfg_pend  <= 1'b0;
    end else begin
      cfg_q     <= cfg_pins;
      started_q <= 1'b1;
      if (!started_q || cfg_pins != cfg_q)
        cfg_pend <= 1'b1;  // a new change wins over a move in the same cycle
      else if (cfg_move)
        cfg_pend <= 1'b0;
    end
  end

  // arbitration, config report always ahead of the message slot
  assign cfg_move = cfg_pend && enq_ready;
  assign msg_move = msg_valid && !cfg_pend && enq_ready;

  assign enq.valid = cfg_pend || msg_valid;
  assign enq.data  = cfg_pend ? cfg_byte(cfg_q[3:2], cfg_q[1], cfg_q[0]) : msg_data;

  // count what the fifo holds plus what is already waiting for it
  assign occupancy = (count_w + 1)'(fifo_count) + (count_w + 1)'(cfg_pend)
                   + (count_w + 1)'(msg_valid);

  assign msg_wr   = wr_req && bus_req.addr == reg_mcu_msg;
  assign msg_drop = msg_wr && ((msg_valid && !msg_move)
                             || occupancy >= (count_w + 1)'(FIFO_DEPTH));

  always_ff @(posedge sys_clock) begin
    if (reset) begin
      msg_valid <= 1'b0;
      drops_q   <= 8'h00;
      mcu_msg_q <= 8'h00;
    end else begin
      if (msg_wr && !msg_drop) begin
        msg_valid <= 1'b1;  // slot refilled even when the old byte leaves now
        mcu_msg_q <= bus_req.data;
      end else if (msg_move) begin
        msg_valid <= 1'b0;
      end
      if (msg_drop && drops_q != 8'hff)
        drops_q <= drops_q + 8'd1;  // sticks at ff
    end
  end

  always_ff @(posedge sys_clock) begin
    if (msg_wr && !msg_drop)
      msg_data <= bus_req.data;
  end

endmodule : vic_bus_regs

// ==== hdl/vic_pkg.sv ====
package vic_pkg;

  // one sample of the cpu side register bus
  typedef struct packed {
    logic       ce;    // low = chip selected
    logic       rw;    // low = write, high = read
    logic [5:0] addr;  // only the low six address lines reach the chip
    logic [7:0] data;  // dbi as driven by the cpu
  } bus_req_t;

  // one byte offered on a valid/ready hop
  typedef struct packed {
    logic [7:0] data;
    logic       valid;  // held until the byte moves
  } msg_t;

  // register map
  localparam logic [5:0] reg_scratch = 6'd0;  // plain read/write
  localparam logic [5:0] reg_status  = 6'd1;  // fifo count and config pins
  localparam logic [5:0] reg_drops   = 6'd2;  // saturating drop counter
  localparam logic [5:0] reg_mcu_msg = 6'd3;  // write enqueues a byte

  // upper half of every config report
  localparam logic [3:0] cfg_tag = 4'hc;

  // config report byte
  // tag in 7..4, chip in 3..2, 15khz in 1, hide raster lines in 0
  function automatic logic [7:0] cfg_byte(
    input logic [1:0] chip,
    input logic       is_15khz,
    input logic       is_hide_raster_lines
  );
    cfg_byte = {cfg_tag, chip, is_15khz, is_hide_raster_lines};
  endfunction

endpackage : vic_pkg
